// File: bench/stack_core_checker.sv
module stack_core_checker (
  input logic                 clk,
  input logic                 rst,
  input core_pkg::prog_addr_t prog_addr,
  input logic                 send,
  input core_pkg::word_t      send_data
);

  // Number of failed assertions, read by the testbench
  int unsigned failures = 0;

  send_low_in_reset: assert property (@(posedge clk) rst |-> !send)
    else begin
      failures++;
      $error("send was raised while the core was held in reset");
    end

  // Reset takes hold on the first edge it is seen, so the PC check looks one cycle later
  pc_zero_in_reset: assert property (@(posedge clk) rst |=> prog_addr == '0)
    else begin
      failures++;
      $error("prog_addr was not address 0 during reset");
    end

  // A strobe must always carry a defined word
  send_data_known: assert property (@(posedge clk) send |-> !$isunknown(send_data))
    else begin
      failures++;
      $error("send_data has unknown bits while send is high");
    end

endmodule

bind stack_core stack_core_checker i_stack_core_checker (
  .clk(clk),
  .rst(rst),
  .prog_addr(prog_addr),
  .send(send),
  .send_data(send_data)
);

// File: bench/stack_core_tb.sv
`include "core_macros.svh"

module stack_core_tb;
  import core_pkg::*;

  localparam int ROM_DEPTH = 1 << `CORE_PROG_ADDR_WIDTH;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_SEED = 4;
  // 29 programs of at most 40 words, each word run at most 12 times in a loop
  localparam int RUNS = 29;
  localparam int MAX_PROG_LEN = 40;
  localparam int MAX_PASSES = 12;
  localparam int TIMEOUT_CYCLES = RUNS * (RESET_CYCLES + 3 + MAX_PROG_LEN * MAX_PASSES) + 200;

  logic clk;
  logic rst;
  prog_addr_t prog_addr;
  instr_t instr;
  logic send;
  word_t send_data;

  instr_t rom [ROM_DEPTH];
  instr_t prog [$];
  word_t sent [$];
  word_t expected [$];
  prog_addr_t halt_addr;
  int unsigned cycles = 0;

  stack_core i_stack_core (
    .clk(clk),
    .rst(rst),
    .prog_addr(prog_addr),
    .instr(instr),
    .send(send),
    .send_data(send_data)
  );

  // Program memory is read combinationally at the current address
  assign instr = rom[prog_addr];

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (i_stack_core.i_stack_core_checker.failures != 0) begin
      $display("An assertion in the bound checker failed");
      stop_with_failure();
    end else if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles without the core reaching HALT", cycles);
      stop_with_failure();
    end
  end

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s sent %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(input prog_addr_t got, input prog_addr_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s stopped at %h, expected %h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // Unused words hold a HALT tagged with their own address
  function automatic instr_t halt_fill(input int addr);
    instr_t w;
    w.opcode = OP_HALT;
    w.imm = word_t'(addr);
    return w;
  endfunction

  task automatic emit(input opcode_t op, input word_t imm);
    instr_t w;
    w.opcode = op;
    w.imm = imm;
    prog.push_back(w);
  endtask

  // Below is the second element and above is the top of stack
  function automatic word_t alu_model(input opcode_t op, input word_t below, input word_t above);
    case (op)
      OP_ADD:  return below + above;
      OP_SUB:  return below - above;
      OP_AND:  return below & above;
      OP_OR:   return below | above;
      default: return below ^ above;
    endcase
  endfunction

  function automatic opcode_t alu_opcode(input int unsigned pick);
    case (pick)
      0:       return OP_ADD;
      1:       return OP_SUB;
      2:       return OP_AND;
      3:       return OP_OR;
      default: return OP_XOR;
    endcase
  endfunction

  task automatic run_program();
    int a;
    logic done;
    done = 1'b0;
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    for (a = 0; a < ROM_DEPTH; a++) begin
      if (a < prog.size()) begin
        rom[a] = prog[a];
      end else begin
        rom[a] = halt_fill(a);
      end
    end
    repeat (RESET_CYCLES - 1) @(posedge clk);
    rst <= 1'b0;
    sent.delete();
    // Falling edge sampling keeps clear of the PC update on the rising edge
    while (!done) begin
      @(negedge clk);
      if (send) begin
        sent.push_back(send_data);
      end
      if (instr.opcode == OP_HALT) begin
        halt_addr = prog_addr;
        done = 1'b1;
      end
    end
    @(negedge clk);
    check_addr(prog_addr, halt_addr, "PC one cycle after HALT");
  endtask

  task automatic run_and_compare(input prog_addr_t exp_halt, input string name);
    run_program();
    if (sent.size() != expected.size()) begin
      $display("Mismatch at time %0t: %s sent %0d words, expected %0d",
               $time, name, sent.size(), expected.size());
      stop_with_failure();
    end
    foreach (expected[i]) begin
      check_word(sent[i], expected[i], name);
    end
    check_addr(halt_addr, exp_halt, name);
    prog.delete();
    expected.delete();
  endtask

  task automatic stack_and_logic_ops();
    // A send before any push shows the cleared top of stack
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 16'h1234);
    emit(OP_PUSHI, 16'h00ff);
    emit(OP_DUP, 0);
    emit(OP_SEND, 0);
    emit(OP_DROP, 0);
    emit(OP_SWAP, 0);
    emit(OP_SEND, 0);
    emit(OP_AND, 0);
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 16'h0f0f);
    emit(OP_OR, 0);
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 16'hffff);
    emit(OP_XOR, 0);
    emit(OP_SEND, 0);
    // Four more pushes spill the older entries into the stack array
    for (int v = 1; v <= 4; v++) begin
      emit(OP_PUSHI, word_t'(v));
    end
    repeat (4) begin
      emit(OP_SEND, 0);
      emit(OP_DROP, 0);
    end
    emit(OP_SEND, 0);
    emit(OP_HALT, 0);
    // 1234 & 00ff, then | 0f0f, then ^ ffff
    expected = '{16'h0000, 16'h00ff, 16'h1234, 16'h0034, 16'h0f3f, 16'hf0c0,
                 16'h0004, 16'h0003, 16'h0002, 16'h0001, 16'hf0c0};
    run_and_compare(prog_addr_t'(prog.size() - 1), "stack and logic ops");
  endtask

  task automatic carry_and_jc();
    emit(OP_PUSHI, 16'hfff0);
    emit(OP_PUSHI, 16'h0020);
    emit(OP_ADD, 0);
    emit(OP_SEND, 0);
    emit(OP_JC, 7);
    emit(OP_PUSHI, 16'hbad0);
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 16'h0001);
    emit(OP_ADD, 0);
    emit(OP_SEND, 0);
    emit(OP_JC, 13);
    emit(OP_PUSHI, 16'h0022);
    emit(OP_SEND, 0);
    // 0011 - 0022 borrows, so the carry is set again
    emit(OP_SUB, 0);
    emit(OP_SEND, 0);
    emit(OP_JC, 18);
    emit(OP_PUSHI, 16'hbad1);
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 16'h0005);
    emit(OP_SUB, 0);
    emit(OP_SEND, 0);
    emit(OP_JC, 24);
    emit(OP_PUSHI, 16'h0033);
    emit(OP_SEND, 0);
    emit(OP_HALT, 0);
    expected = '{16'h0010, 16'h0011, 16'h0022, 16'hffef, 16'hffea, 16'h0033};
    run_and_compare(8'd24, "carry and JC");
  endtask

  task automatic jumps_and_jz();
    emit(OP_PUSHI, 1);
    emit(OP_SEND, 0);
    emit(OP_JMP, 5);
    emit(OP_PUSHI, 16'hdead);
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 0);
    emit(OP_JZ, 9);
    emit(OP_PUSHI, 16'hdead);
    emit(OP_SEND, 0);
    emit(OP_SEND, 0);
    emit(OP_PUSHI, 7);
    emit(OP_JZ, 15);
    emit(OP_PUSHI, 2);
    emit(OP_SEND, 0);
    emit(OP_JMP, 17);
    emit(OP_PUSHI, 16'hdead);
    emit(OP_SEND, 0);
    emit(OP_HALT, 0);
    expected = '{16'h0001, 16'h0001, 16'h0002};
    run_and_compare(8'd17, "JMP and JZ");
  endtask

  task automatic nested_calls();
    emit(OP_PUSHI, 1);
    emit(OP_SEND, 0);
    emit(OP_CALL, 6);
    emit(OP_PUSHI, 5);
    emit(OP_SEND, 0);
    emit(OP_HALT, 0);
    // First level subroutine at 6 calls the second level at 12
    emit(OP_PUSHI, 2);
    emit(OP_SEND, 0);
    emit(OP_CALL, 12);
    emit(OP_PUSHI, 4);
    emit(OP_SEND, 0);
    emit(OP_RET, 0);
    emit(OP_PUSHI, 3);
    emit(OP_SEND, 0);
    emit(OP_RET, 0);
    expected = '{16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0005};
    run_and_compare(8'd5, "nested CALL and RET");
  endtask

  task automatic single_loop(input int count);
    emit(OP_PUSHI, 0);
    emit(OP_PUSHI, word_t'(count));
    emit(OP_LOOP, 6);
    emit(OP_PUSHI, 1);
    emit(OP_ADD, 0);
    emit(OP_SEND, 0);
    emit(OP_HALT, 0);
    for (int k = 1; k <= count; k++) begin
      expected.push_back(word_t'(k));
    end
    run_and_compare(8'd6, "counted loop");
  endtask

  task automatic nested_loops(input int outer, input int inner);
    emit(OP_PUSHI, 0);
    emit(OP_PUSHI, word_t'(outer));
    emit(OP_LOOP, 9);
    emit(OP_PUSHI, word_t'(inner));
    emit(OP_LOOP, 8);
    emit(OP_PUSHI, 1);
    emit(OP_ADD, 0);
    emit(OP_SEND, 0);
    // The outer body ends one word after the inner one
    emit(OP_NOP, 0);
    emit(OP_HALT, 0);
    for (int k = 1; k <= outer * inner; k++) begin
      expected.push_back(word_t'(k));
    end
    run_and_compare(8'd9, "nested loops");
  endtask

  task automatic break_out_of_loop();
    emit(OP_PUSHI, 0);
    emit(OP_PUSHI, 10);
    emit(OP_LOOP, 13);
    emit(OP_PUSHI, 1);
    emit(OP_ADD, 0);
    emit(OP_SEND, 0);
    emit(OP_DUP, 0);
    emit(OP_PUSHI, 4);
    emit(OP_XOR, 0);
    emit(OP_JZ, 11);
    emit(OP_JMP, 12);
    emit(OP_BREAK, 0);
    emit(OP_NOP, 0);
    emit(OP_HALT, 0);
    expected = '{16'h0001, 16'h0002, 16'h0003, 16'h0004};
    run_and_compare(8'd13, "loop with BREAK");
  endtask

  task automatic random_alu_programs(input int runs);
    word_t acc;
    word_t operand;
    opcode_t op;
    int steps;
    for (int r = 0; r < runs; r++) begin
      acc = word_t'($urandom);
      steps = $urandom_range(8, 3);
      emit(OP_PUSHI, acc);
      for (int s = 0; s < steps; s++) begin
        operand = word_t'($urandom);
        op = alu_opcode($urandom_range(4, 0));
        emit(OP_PUSHI, operand);
        if ($urandom_range(1, 0) == 1) begin
          // After a swap the running value is the top operand
          emit(OP_SWAP, 0);
          acc = alu_model(op, operand, acc);
        end else begin
          acc = alu_model(op, acc, operand);
        end
        emit(op, 0);
        emit(OP_SEND, 0);
        expected.push_back(acc);
      end
      emit(OP_HALT, 0);
      run_and_compare(prog_addr_t'(prog.size() - 1), "random ALU program");
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    void'($urandom(RANDOM_SEED));
    for (int a = 0; a < ROM_DEPTH; a++) begin
      rom[a] = halt_fill(a);
    end
    stack_and_logic_ops();
    carry_and_jc();
    jumps_and_jz();
    nested_calls();
    single_loop(3);
    single_loop(1);
    single_loop(0);
    nested_loops(3, 4);
    break_out_of_loop();
    random_alu_programs(20);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+rtl
rtl/core_pkg.sv
rtl/lifo_stack.sv
rtl/data_stack.sv
rtl/alu.sv
rtl/instr_decode.sv
rtl/loop_control.sv
rtl/pc_control.sv
rtl/stack_core.sv
bench/stack_core_checker.sv
bench/stack_core_tb.sv

// File: rtl/alu.sv
module alu (
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  input  core_pkg::alu_op_t op,
  input  logic              carry_in,
  output core_pkg::word_t   result,
  output logic              carry_out
);
  import core_pkg::*;

  logic [$bits(word_t):0] wide;

  always_comb begin
    wide = '0;
    result = '0;
    carry_out = 1'b0;
    case (op)
      ALU_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        {carry_out, result} = wide;
      end
      ALU_SUB: begin
        // The top bit of the difference is the borrow
        wide = {1'b0, a} - {1'b0, b};
        {carry_out, result} = wide;
      end
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      default: begin
        // Pass leaves the stored carry as it was
        result = b;
        carry_out = carry_in;
      end
    endcase
  end

endmodule

// File: rtl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Width of a data word on the stack and in the ALU
`define CORE_WORD_WIDTH 16

// Width of a program memory address
`define CORE_PROG_ADDR_WIDTH 8

// Entries kept in the data stack array below the top two registers
`define CORE_DSTACK_DEPTH 16

// Return addresses the call stack can hold
`define CORE_CSTACK_DEPTH 4

// Saved loop frames, so one more loop can be active on top of these
`define CORE_LSTACK_DEPTH 3

`endif

// File: rtl/core_pkg.sv
`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_WORD_WIDTH-1:0] word_t;
  typedef logic [`CORE_PROG_ADDR_WIDTH-1:0] prog_addr_t;

  // Opcodes are grouped by function in the upper nibble
  typedef enum logic [7:0] {
    OP_NOP   = 8'h00,
    OP_PUSHI = 8'h01,
    OP_DROP  = 8'h02,
    OP_DUP   = 8'h03,
    OP_SWAP  = 8'h04,
    OP_ADD   = 8'h10,
    OP_SUB   = 8'h11,
    OP_AND   = 8'h12,
    OP_OR    = 8'h13,
    OP_XOR   = 8'h14,
    OP_JMP   = 8'h20,
    OP_JZ    = 8'h21,
    OP_JC    = 8'h22,
    OP_CALL  = 8'h23,
    OP_RET   = 8'h24,
    OP_LOOP  = 8'h30,
    OP_BREAK = 8'h31,
    OP_SEND  = 8'h40,
    OP_HALT  = 8'hff
  } opcode_t;

  // The immediate sits above the opcode in the program word
  typedef struct packed {
    word_t   imm;
    opcode_t opcode;
  } instr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {
    HOLD,
    PUSH,
    POP,
    POP_REPLACE
  } stack_move_t;

  // Body runs from beginning up to the instruction before ending
  typedef struct packed {
    prog_addr_t beginning;
    prog_addr_t ending;
    word_t      total;
    word_t      index;
  } loop_frame_t;

endpackage

// File: rtl/data_stack.sv
`include "core_macros.svh"

module data_stack (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::stack_move_t move,
  input  logic                  swap,
  input  logic                  next_top_sel,
  input  core_pkg::word_t       next_top,
  input  core_pkg::word_t       imm,
  output core_pkg::word_t       top,
  output core_pkg::word_t       second
);
  import core_pkg::*;

  localparam int PTR_W = $clog2(`CORE_DSTACK_DEPTH);

  word_t mem [`CORE_DSTACK_DEPTH];
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] ptr_up;
  word_t new_top;

  // Pushes take either the immediate or the ALU result
  assign new_top = next_top_sel ? imm : next_top;
  assign ptr_up = ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
      top <= '0;
      second <= '0;
    end else begin
      case (move)
        PUSH: begin
          top <= new_top;
          second <= top;
          ptr <= ptr_up;
        end
        POP: begin
          top <= second;
          second <= mem[ptr];
          ptr <= ptr - 1'b1;
        end
        POP_REPLACE: begin
          top <= new_top;
          second <= mem[ptr];
          ptr <= ptr - 1'b1;
        end
        default: begin
          // A swap exchanges the two registers and leaves the array alone
          if (swap) begin
            top <= second;
            second <= top;
          end
        end
      endcase
    end
  end

  // Second spills into the array on every push, and the pointer simply wraps
  always_ff @(posedge clk) begin
    if (move == PUSH) begin
      mem[ptr_up] <= second;
    end
  end

endmodule

// File: rtl/instr_decode.sv
module instr_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::instr_t      instr,
  input  core_pkg::word_t       top,
  input  logic                  alu_carry,
  input  logic                  loop_skip,
  output core_pkg::prog_addr_t  imm_addr,
  output core_pkg::stack_move_t move,
  output logic                  next_top_sel,
  output logic                  swap,
  output core_pkg::alu_op_t     alu_op,
  output logic                  jump,
  output logic                  jump_cond_taken,
  output logic                  call,
  output logic                  ret,
  output logic                  loop_start,
  output logic                  loop_break,
  output logic                  halt,
  output logic                  send,
  output logic                  carry
);
  import core_pkg::*;

  logic carry_we;

  // Jump, call and loop targets use the low bits of the immediate
  assign imm_addr = prog_addr_t'(instr.imm);

  always_comb begin
    move = HOLD;
    next_top_sel = 1'b0;
    swap = 1'b0;
    alu_op = ALU_PASS_B;
    carry_we = 1'b0;
    jump = 1'b0;
    jump_cond_taken = 1'b0;
    call = 1'b0;
    ret = 1'b0;
    loop_start = 1'b0;
    loop_break = 1'b0;
    halt = 1'b0;
    send = 1'b0;
    case (instr.opcode)
      OP_PUSHI: begin
        move = PUSH;
        next_top_sel = 1'b1;
      end
      OP_DROP: move = POP;
      // DUP pushes the ALU pass-through of the top
      OP_DUP:  move = PUSH;
      OP_SWAP: swap = 1'b1;
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
        move = POP_REPLACE;
        carry_we = 1'b1;
        case (instr.opcode)
          OP_ADD:  alu_op = ALU_ADD;
          OP_SUB:  alu_op = ALU_SUB;
          OP_AND:  alu_op = ALU_AND;
          OP_OR:   alu_op = ALU_OR;
          default: alu_op = ALU_XOR;
        endcase
      end
      OP_JMP: jump = 1'b1;
      OP_JZ: begin
        move = POP;
        jump_cond_taken = (top == '0);
      end
      OP_JC:   jump_cond_taken = carry;
      OP_CALL: call = 1'b1;
      OP_RET:  ret = 1'b1;
      OP_LOOP: begin
        // The count is consumed either way; a zero count jumps past the body
        move = POP;
        loop_start = !loop_skip;
        jump = loop_skip;
      end
      OP_BREAK: loop_break = 1'b1;
      // The strobe stays low while the core is held in reset
      OP_SEND:  send = !rst;
      OP_HALT:  halt = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
    end else if (carry_we) begin
      carry <= alu_carry;
    end
  end

endmodule

// File: rtl/lifo_stack.sv
module lifo_stack #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  logic     pop,
  input  payload_t insert,
  output payload_t top_item,
  output logic     empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] top_idx;
  logic [PTR_W-1:0] up_idx;
  logic [PTR_W-1:0] down_idx;
  logic [CNT_W-1:0] count;

  // The pointer wraps so a push on a full stack overwrites the oldest entry
  assign up_idx = (top_idx == PTR_W'(DEPTH - 1)) ? '0 : top_idx + 1'b1;
  assign down_idx = (top_idx == '0) ? PTR_W'(DEPTH - 1) : top_idx - 1'b1;

  assign empty = (count == '0);
  assign top_item = mem[top_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      top_idx <= '0;
      count <= '0;
    end else if (push) begin
      top_idx <= up_idx;
      if (count != CNT_W'(DEPTH)) begin
        count <= count + 1'b1;
      end
    end else if (pop && !empty) begin
      top_idx <= down_idx;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[up_idx] <= insert;
    end
  end

endmodule

// File: rtl/loop_control.sv
`include "core_macros.svh"

module loop_control (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 loop_start,
  input  logic                 loop_break,
  input  logic                 halt,
  input  core_pkg::word_t      count,
  input  core_pkg::prog_addr_t loop_end,
  input  core_pkg::prog_addr_t pc_advance,
  output logic                 loop_next,
  output logic                 loop_exit,
  output logic                 loop_skip,
  output core_pkg::prog_addr_t loop_target
);
  import core_pkg::*;

  loop_frame_t frame;
  loop_frame_t saved;
  logic active;
  logic saved_empty;
  logic save_frame;
  logic at_end;
  word_t index_next;

  // Only an active loop is worth saving when a new one starts
  assign save_frame = loop_start && active;

  lifo_stack #(
    .payload_t(loop_frame_t),
    .DEPTH(`CORE_LSTACK_DEPTH)
  ) i_loop_stack (
    .clk(clk),
    .rst(rst),
    .push(save_frame),
    .pop(loop_exit),
    .insert(frame),
    .top_item(saved),
    .empty(saved_empty)
  );

  // Decode only looks at this on a LOOP instruction, where count is the popped top
  assign loop_skip = (count == '0);

  assign index_next = frame.index + 1'b1;
  assign at_end = active && !halt && !loop_start && (pc_advance == frame.ending);
  assign loop_exit = active && !halt && !loop_start &&
                     (loop_break || (at_end && index_next == frame.total));
  assign loop_next = at_end && !loop_exit;
  assign loop_target = loop_exit ? frame.ending : frame.beginning;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else if (loop_start) begin
      active <= 1'b1;
      frame.beginning <= pc_advance;
      frame.ending <= loop_end;
      frame.total <= count;
      frame.index <= '0;
    end else if (loop_exit) begin
      // Leaving the outermost loop clears the active frame
      if (saved_empty) begin
        active <= 1'b0;
      end else begin
        frame <= saved;
      end
    end else if (loop_next) begin
      frame.index <= index_next;
    end
  end

endmodule

// File: rtl/pc_control.sv
`include "core_macros.svh"

module pc_control (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 halt,
  input  logic                 jump,
  input  logic                 jump_cond_taken,
  input  logic                 call,
  input  logic                 ret,
  input  logic                 loop_next,
  input  logic                 loop_exit,
  input  core_pkg::prog_addr_t loop_target,
  input  core_pkg::prog_addr_t imm,
  output core_pkg::prog_addr_t prog_addr,
  output core_pkg::prog_addr_t pc_advance
);
  import core_pkg::*;

  prog_addr_t pc;
  prog_addr_t pc_next;
  prog_addr_t ret_addr;
  logic call_empty;

  // Calls save the address after the call instruction
  lifo_stack #(
    .payload_t(prog_addr_t),
    .DEPTH(`CORE_CSTACK_DEPTH)
  ) i_call_stack (
    .clk(clk),
    .rst(rst),
    .push(call),
    .pop(ret),
    .insert(pc_advance),
    .top_item(ret_addr),
    .empty(call_empty)
  );

  assign pc_advance = pc + 1'b1;
  assign prog_addr = pc;

  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (ret && !call_empty) begin
      pc_next = ret_addr;
    end else if (jump || jump_cond_taken || call) begin
      pc_next = imm;
    end else if (loop_exit || loop_next) begin
      pc_next = loop_target;
    end else begin
      // A return with nothing on the call stack falls through
      pc_next = pc_advance;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: rtl/stack_core.sv
module stack_core (
  input  logic                 clk,
  input  logic                 rst,
  output core_pkg::prog_addr_t prog_addr,
  input  core_pkg::instr_t     instr,
  output logic                 send,
  output core_pkg::word_t      send_data
);
  import core_pkg::*;

  stack_move_t move;
  alu_op_t alu_op;
  word_t second;
  word_t alu_result;
  prog_addr_t imm_addr;
  prog_addr_t pc_advance;
  prog_addr_t loop_target;
  logic next_top_sel;
  logic swap;
  logic carry;
  logic alu_carry;
  logic jump;
  logic jump_cond_taken;
  logic call;
  logic ret;
  logic loop_start;
  logic loop_break;
  logic halt;
  logic loop_next;
  logic loop_exit;
  logic loop_skip;

  // The top of stack is wired straight out as the send word
  instr_decode i_instr_decode (
    .clk(clk),
    .rst(rst),
    .instr(instr),
    .top(send_data),
    .alu_carry(alu_carry),
    .loop_skip(loop_skip),
    .imm_addr(imm_addr),
    .move(move),
    .next_top_sel(next_top_sel),
    .swap(swap),
    .alu_op(alu_op),
    .jump(jump),
    .jump_cond_taken(jump_cond_taken),
    .call(call),
    .ret(ret),
    .loop_start(loop_start),
    .loop_break(loop_break),
    .halt(halt),
    .send(send),
    .carry(carry)
  );

  alu i_alu (
    .a(second),
    .b(send_data),
    .op(alu_op),
    .carry_in(carry),
    .result(alu_result),
    .carry_out(alu_carry)
  );

  data_stack i_data_stack (
    .clk(clk),
    .rst(rst),
    .move(move),
    .swap(swap),
    .next_top_sel(next_top_sel),
    .next_top(alu_result),
    .imm(instr.imm),
    .top(send_data),
    .second(second)
  );

  loop_control i_loop_control (
    .clk(clk),
    .rst(rst),
    .loop_start(loop_start),
    .loop_break(loop_break),
    .halt(halt),
    .count(send_data),
    .loop_end(imm_addr),
    .pc_advance(pc_advance),
    .loop_next(loop_next),
    .loop_exit(loop_exit),
    .loop_skip(loop_skip),
    .loop_target(loop_target)
  );

  pc_control i_pc_control (
    .clk(clk),
    .rst(rst),
    .halt(halt),
    .jump(jump),
    .jump_cond_taken(jump_cond_taken),
    .call(call),
    .ret(ret),
    .loop_next(loop_next),
    .loop_exit(loop_exit),
    .loop_target(loop_target),
    .imm(imm_addr),
    .prog_addr(prog_addr),
    .pc_advance(pc_advance)
  );

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module stack_core_tb -o stack_core_sim

./obj_dir/stack_core_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
